// ==== design/masku_macros.svh ====
`ifndef MASKU_MACROS_SVH
`define MASKU_MACROS_SVH

// Datapath and result word width in bits
`define MASKU_WORD_W 64

// Width of vl and of the element counters
`define MASKU_VLEN_W 16

// Destination register word address width
`define MASKU_ADDR_W 8

// Instruction id width
`define MASKU_ID_W 3

// Operand buffer depth, which is also the credit count granted to the source
`define MASKU_OPND_DEPTH 2

// Result queue depth and the sink credits we own after reset
`define MASKU_RES_DEPTH 2
`define MASKU_RES_CREDITS 2

`endif

// ==== design/masku_cfg_pkg.sv ====
`include "masku_macros.svh"

package masku_cfg_pkg;

  //////////////////////////////////////////////////
  // Data types sized by the configuration macros
  //////////////////////////////////////////////////

  // One datapath word
  // Holds 64 mask bits or a full operand
  typedef logic [`MASKU_WORD_W-1:0] word_t;

  // Element count
  // Wide enough for the largest vl
  typedef logic [`MASKU_VLEN_W-1:0] vlen_t;

  // Word address inside the destination register
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // Instruction id
  // Returned with the done pulse
  typedef logic [`MASKU_ID_W-1:0] vid_t;

endpackage

// ==== design/masku_insn_pkg.sv ====
`include "masku_macros.svh"

package masku_insn_pkg;
  import masku_cfg_pkg::*;

  // Operation class
  typedef enum logic {
    OP_MLOGIC = 1'b0,
    OP_MCMP   = 1'b1
  } masku_op_e;

  // Element width of the compare results
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  // Counts elements inside one word, 0 up to the full word
  typedef logic [$clog2(`MASKU_WORD_W):0] elem_cnt_t;

  // Instruction as issued to the unit
  // vm set means unmasked
  typedef struct packed {
    masku_op_e op;
    sew_e      sew;
    logic      vm;
    vlen_t     vl;
    vaddr_t    vd;
    vid_t      id;
  } insn_t;

  // Operand beat, all three channels travel together
  typedef struct packed {
    word_t a;
    word_t b;
    word_t m;
  } opnd_beat_t;

  // Per-beat control from decode to execute
  typedef struct packed {
    masku_op_e op;
    sew_e      sew;
    logic      vm;
    elem_cnt_t elem_base;
    elem_cnt_t elem_cnt;
    logic      close;
    vaddr_t    addr;
    vid_t      id;
    logic      last;
  } beat_ctl_t;

  // Result word with its destination
  typedef struct packed {
    word_t  wdata;
    vaddr_t addr;
    vid_t   id;
    logic   last;
  } result_t;

endpackage

// ==== design/masku_fifo.sv ====
`timescale 1ns/100ps

module masku_fifo #(
  parameter type         elem_t = logic,
  parameter int unsigned DEPTH  = 2
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  elem_t data_i,
  input  logic  pop_i,
  output elem_t data_o,
  output logic  empty_o,
  output logic  full_o
);

  // Pointers need at least one bit even for a single entry
  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PtrW-1:0]            ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  elem_t mem_q [DEPTH];
  ptr_t  wr_ptr_q, rd_ptr_q;
  cnt_t  cnt_q;
  logic  do_push, do_pop;

  // Wrap a pointer at the last entry
  function automatic ptr_t next_ptr(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == cnt_t'(DEPTH));

  // Pushes into a full buffer and pops from an empty one are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Show-ahead read of the oldest entry
  assign data_o = mem_q[rd_ptr_q];

  // Storage array
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      unique case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

// ==== design/masku_decode.sv ====
`timescale 1ns/100ps

`include "masku_macros.svh"

module masku_decode import masku_cfg_pkg::*; import masku_insn_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction handshake
  input  insn_t     insn_i,
  input  logic      insn_valid_i,
  output logic      insn_ready_o,
  // Operand buffer
  input  logic      beat_empty_i,
  output logic      beat_pop_o,
  // Execute stage
  input  logic      exe_ready_i,
  output logic      ctl_valid_o,
  output beat_ctl_t ctl_o
);

  //////////////////////////////////////////////////
  // Instruction state
  //////////////////////////////////////////////////

  // Held instruction and its busy flag
  insn_t     insn_q;
  logic      busy_q;
  // Elements not yet read from the operand buffer
  vlen_t     rem_q;
  // Destination word index relative to vd
  vaddr_t    word_idx_q;
  // Elements already gathered into the current packed word
  elem_cnt_t base_q;

  elem_cnt_t per_beat;
  elem_cnt_t elem_cnt;
  logic      last_beat;
  logic      close_word;

  assign insn_ready_o = !busy_q;

  // Merge beats span a whole word
  // Packing beats carry one element per element-width slot
  assign per_beat = (insn_q.op == OP_MLOGIC) ? elem_cnt_t'(`MASKU_WORD_W) :
                    (elem_cnt_t'(`MASKU_WORD_W / 8) >> insn_q.sew);

  // Tail beat carries only the remaining elements
  assign last_beat = (rem_q <= vlen_t'(per_beat));
  assign elem_cnt  = last_beat ? elem_cnt_t'(rem_q) : per_beat;

  // Packed word is complete when full or at the end of vl
  assign close_word = (insn_q.op == OP_MLOGIC) || last_beat ||
                      ((base_q + elem_cnt) == elem_cnt_t'(`MASKU_WORD_W));

  // Beat goes to execute in the same cycle it is popped
  assign ctl_valid_o = busy_q && !beat_empty_i;
  assign beat_pop_o  = ctl_valid_o && exe_ready_i;

  assign ctl_o = '{
    op:        insn_q.op,
    sew:       insn_q.sew,
    vm:        insn_q.vm,
    elem_base: base_q,
    elem_cnt:  elem_cnt,
    close:     close_word,
    addr:      insn_q.vd + word_idx_q,
    id:        insn_q.id,
    last:      last_beat
  };

  // Instruction fields captured on acceptance
  always_ff @(posedge clk_i) begin
    if (insn_valid_i && !busy_q) begin
      insn_q <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      rem_q      <= '0;
      word_idx_q <= '0;
      base_q     <= '0;
    end else if (!busy_q) begin
      // Accept and initialise counters
      if (insn_valid_i) begin
        busy_q     <= 1'b1;
        rem_q      <= insn_i.vl;
        word_idx_q <= '0;
        base_q     <= '0;
      end
    end else if (beat_pop_o) begin
      rem_q <= rem_q - vlen_t'(elem_cnt);
      if (close_word) begin
        word_idx_q <= word_idx_q + 1'b1;
        base_q     <= '0;
      end else begin
        base_q <= base_q + elem_cnt;
      end
      // Release after the last beat
      if (last_beat) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== design/masku_execute.sv ====
`timescale 1ns/100ps

`include "masku_macros.svh"

module masku_execute import masku_cfg_pkg::*; import masku_insn_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // From decode
  input  logic       ctl_valid_i,
  input  beat_ctl_t  ctl_i,
  input  opnd_beat_t beat_i,
  output logic       ready_o,
  // To the result queue
  output logic       res_valid_o,
  output result_t    res_o,
  input  logic       res_ready_i
);

  localparam int unsigned MaxPack = `MASKU_WORD_W / 8;

  // Output register
  result_t res_q;
  logic    valid_q;
  // Packed compare bits gathered so far
  word_t   acc_q;

  logic                 accept;
  logic [MaxPack-1:0]   cmp_bits;
  word_t                acc_next;
  word_t                bit_en;
  elem_cnt_t            span;
  word_t                wdata;

  // Ones below bit n
  function automatic word_t tail_mask(input elem_cnt_t n);
    word_t lsb;
    lsb = '0;
    for (int j = 0; j < `MASKU_WORD_W; j++) begin
      lsb[j] = (j < n);
    end
    return lsb;
  endfunction

  // Stall while the register holds a word the queue cannot take
  assign ready_o = !valid_q || res_ready_i;
  assign accept  = ctl_valid_i && ready_o;

  //////////////////////////////////////////////////
  // Mask ALU
  //////////////////////////////////////////////////

  always_comb begin : p_mask_alu
    word_t shifted;
    shifted = '0;
    // Compare bit is the lowest bit of each element of a
    for (int k = 0; k < MaxPack; k++) begin
      shifted     = beat_i.a >> (k << (3 + ctl_i.sew));
      cmp_bits[k] = shifted[0] && (k < ctl_i.elem_cnt);
    end
    acc_next = acc_q | (word_t'(cmp_bits) << ctl_i.elem_base);

    // Merge looks at this beat only, packing at the whole word
    span   = (ctl_i.op == OP_MLOGIC) ? ctl_i.elem_cnt : ctl_i.elem_base + ctl_i.elem_cnt;
    bit_en = tail_mask(span) & (ctl_i.vm ? '1 : beat_i.m);

    // Disabled bits keep the old destination
    if (ctl_i.op == OP_MLOGIC) begin
      wdata = (beat_i.a & bit_en) | (beat_i.b & ~bit_en);
    end else begin
      wdata = (acc_next & bit_en) | (beat_i.b & ~bit_en);
    end
  end

  assign res_valid_o = valid_q;
  assign res_o       = res_q;

  // Payload register
  always_ff @(posedge clk_i) begin
    if (accept && ctl_i.close) begin
      res_q <= '{wdata: wdata, addr: ctl_i.addr, id: ctl_i.id, last: ctl_i.last};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      acc_q   <= '0;
    end else if (accept) begin
      // Only closing beats produce a word
      valid_q <= ctl_i.close;
      acc_q   <= ctl_i.close ? '0 : acc_next;
    end else if (res_ready_i) begin
      valid_q <= 1'b0;
    end
  end

endmodule

// ==== design/masku_result.sv ====
`timescale 1ns/100ps

`include "masku_macros.svh"

module masku_result import masku_cfg_pkg::*; import masku_insn_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // From execute
  input  logic    res_valid_i,
  input  result_t res_i,
  output logic    ready_o,
  // Credit-based output
  output logic    res_valid_o,
  output result_t res_o,
  input  logic    res_credit_i,
  // Completion
  output logic    done_o,
  output vid_t    done_id_o
);

  localparam int unsigned CredW = $clog2(`MASKU_RES_CREDITS + 1);

  typedef logic [CredW-1:0] credit_t;

  credit_t credit_q;
  logic    q_empty;
  logic    q_full;
  logic    send;

  //////////////////////////////////////////////////
  // Result queue
  //////////////////////////////////////////////////

  masku_fifo #(
    .elem_t (result_t),
    .DEPTH  (`MASKU_RES_DEPTH)
  ) i_res_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (res_valid_i && ready_o),
    .data_i  (res_i),
    .pop_i   (send),
    .data_o  (res_o),
    .empty_o (q_empty),
    .full_o  (q_full)
  );

  assign ready_o = !q_full;

  // A word leaves only while the sink has granted a credit
  assign res_valid_o = !q_empty && (credit_q != '0);
  assign send        = res_valid_o;

  // Instruction completes with its last word
  assign done_o    = send && res_o.last;
  assign done_id_o = res_o.id;

  // Output credits, a return and a send in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= credit_t'(`MASKU_RES_CREDITS);
    end else if (res_credit_i && !send) begin
      credit_q <= credit_q + 1'b1;
    end else if (!res_credit_i && send) begin
      credit_q <= credit_q - 1'b1;
    end
  end

endmodule

// ==== design/masku_top.sv ====
`timescale 1ns/100ps

`include "masku_macros.svh"

module masku_top import masku_cfg_pkg::*; import masku_insn_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Instruction input
  input  insn_t      insn_i,
  input  logic       insn_valid_i,
  output logic       insn_ready_o,
  // Operand input with credits
  input  opnd_beat_t opnd_i,
  input  logic       opnd_valid_i,
  output logic       opnd_credit_o,
  // Result output with credits
  output result_t    res_o,
  output logic       res_valid_o,
  input  logic       res_credit_i,
  // Completion
  output logic       done_o,
  output vid_t       done_id_o
);

  opnd_beat_t opnd_beat;
  logic       opnd_empty;
  logic       opnd_pop;
  logic       ctl_valid;
  beat_ctl_t  ctl;
  logic       exe_ready;
  logic       exe_res_valid;
  result_t    exe_res;
  logic       res_ready;

  // Source never overruns the buffer as long as it spends its credits
  masku_fifo #(
    .elem_t (opnd_beat_t),
    .DEPTH  (`MASKU_OPND_DEPTH)
  ) i_opnd_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (opnd_valid_i),
    .data_i  (opnd_i),
    .pop_i   (opnd_pop),
    .data_o  (opnd_beat),
    .empty_o (opnd_empty),
    .full_o  ()
  );

  // Each popped beat frees one buffer slot
  assign opnd_credit_o = opnd_pop;

  masku_decode i_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .beat_empty_i (opnd_empty),
    .beat_pop_o   (opnd_pop),
    .exe_ready_i  (exe_ready),
    .ctl_valid_o  (ctl_valid),
    .ctl_o        (ctl)
  );

  masku_execute i_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ctl_valid_i (ctl_valid),
    .ctl_i       (ctl),
    .beat_i      (opnd_beat),
    .ready_o     (exe_ready),
    .res_valid_o (exe_res_valid),
    .res_o       (exe_res),
    .res_ready_i (res_ready)
  );

  masku_result i_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_valid_i  (exe_res_valid),
    .res_i        (exe_res),
    .ready_o      (res_ready),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .res_credit_i (res_credit_i),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

endmodule

// ==== test/tb_masku_tasks.svh ====
//////////////////////////////////////////////////
// Cycle stepping and the sink and source models
//////////////////////////////////////////////////

// Report a wait that never finished
task automatic report_timeout(input string what);
  $display("Timeout after %0d cycles while waiting for %s", WaitLimit, what);
  $display("TESTBENCH FAILED");
endtask

// Advance to the next falling edge
// Outputs are sampled half a cycle after the rising edge
task automatic next_cycle();
  @(negedge clk_i);
  // Operand credits come back one per popped beat
  if (opnd_credit_o) begin
    opnd_credits++;
    credit_pulses++;
  end
  // Sink takes every word and owes a credit for it
  if (res_valid_o) begin
    got_q.push_back(res_o);
    owed_credits++;
    sink_outstanding++;
  end
  if (done_o) begin
    done_q.push_back(done_id_o);
    if (!(res_valid_o && res_o.last)) begin
      err_cnt++;
      $display("ERR %0t: done pulse without a last result word", $time);
    end
  end
  if (sink_outstanding > `MASKU_RES_CREDITS) begin
    err_cnt++;
    $display("ERR %0t: %0d words sent without credit", $time, sink_outstanding);
  end
  // Sink returns at most one credit per cycle unless held
  res_credit_i = !hold_credits && (owed_credits > 0);
  if (res_credit_i) begin
    owed_credits--;
    sink_outstanding--;
  end
  insn_valid_i = 1'b0;
  opnd_valid_i = 1'b0;
endtask

// Offer an instruction once the unit is free
task automatic send_insn(input insn_t insn);
  int n;
  for (n = 0; n < WaitLimit; n++) begin
    next_cycle();
    if (insn_ready_o) break;
  end
  if (n == WaitLimit) begin
    report_timeout("insn_ready_o");
    $finish;
  end else begin
    insn_i       = insn;
    insn_valid_i = 1'b1;
  end
endtask

// Source spends one operand credit per beat
// A credit pulse frees its slot at the next rising edge, so it is spent a cycle later
task automatic send_beat(input opnd_beat_t beat);
  int   n;
  logic have_credit;
  for (n = 0; n < WaitLimit; n++) begin
    have_credit = (opnd_credits > 0);
    next_cycle();
    if (have_credit) break;
  end
  if (n == WaitLimit) begin
    report_timeout("an operand credit");
    $finish;
  end else begin
    opnd_i       = beat;
    opnd_valid_i = 1'b1;
    opnd_credits--;
  end
endtask

task automatic wait_results(input int count);
  int n;
  for (n = 0; n < WaitLimit; n++) begin
    if (got_q.size() >= count) break;
    next_cycle();
  end
  if (n == WaitLimit) begin
    report_timeout("result words");
    $finish;
  end
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_result(input result_t got, input result_t exp, input int idx);
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t: word %0d got %h addr %0d id %0d last %0b", $time, idx,
             got.wdata, got.addr, got.id, got.last);
    $display("ERR %0t: word %0d exp %h addr %0d id %0d last %0b", $time, idx,
             exp.wdata, exp.addr, exp.id, exp.last);
  end
endtask

task automatic check_done(input vid_t got, input vid_t exp);
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t: done id %0d, expected %0d", $time, got, exp);
  end
endtask

// Single status output against its expected level
task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    err_cnt++;
    $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

// ==== test/tb_masku.sv ====
`timescale 1ns/100ps

`include "masku_macros.svh"

module tb_masku import masku_cfg_pkg::*; import masku_insn_pkg::*; ();

  // Cycle limit of every wait loop
  localparam int WaitLimit = 2000;

  logic       clk_i;
  logic       rst_ni;
  insn_t      insn_i;
  logic       insn_valid_i;
  logic       insn_ready_o;
  opnd_beat_t opnd_i;
  logic       opnd_valid_i;
  logic       opnd_credit_o;
  result_t    res_o;
  logic       res_valid_o;
  logic       res_credit_i;
  logic       done_o;
  vid_t       done_id_o;

  // Source and sink state
  int      opnd_credits;
  int      credit_pulses;
  int      owed_credits;
  int      sink_outstanding;
  bit      hold_credits;
  result_t got_q[$];
  vid_t    done_q[$];
  int      err_cnt;
  int      test_cnt;

  always #5 clk_i = ~clk_i;

  masku_top dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .opnd_i        (opnd_i),
    .opnd_valid_i  (opnd_valid_i),
    .opnd_credit_o (opnd_credit_o),
    .res_o         (res_o),
    .res_valid_o   (res_valid_o),
    .res_credit_i  (res_credit_i),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  `include "tb_masku_tasks.svh"

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Bit j takes src when inside the count and enabled, else the old b
  function automatic word_t blend(input word_t src, input opnd_beat_t bt, input int cnt,
                                  input logic vm);
    word_t w;
    for (int j = 0; j < `MASKU_WORD_W; j++) begin
      w[j] = (j < cnt && (vm || bt.m[j])) ? src[j] : bt.b[j];
    end
    return w;
  endfunction

  function automatic opnd_beat_t random_beat();
    opnd_beat_t bt;
    bt.a = {$urandom, $urandom};
    bt.b = {$urandom, $urandom};
    bt.m = {$urandom, $urandom};
    return bt;
  endfunction

  function automatic insn_t make_insn(input masku_op_e op, input sew_e sew, input logic vm,
                                      input int vl, input vaddr_t vd, input vid_t id);
    insn_t ins;
    ins.op  = op;
    ins.sew = sew;
    ins.vm  = vm;
    ins.vl  = vlen_t'(vl);
    ins.vd  = vd;
    ins.id  = id;
    return ins;
  endfunction

  task automatic report_test(input string name, input int first_err);
    test_cnt++;
    if (err_cnt == first_err) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - first_err);
    end
  endtask

  // Compare collected words and the single done pulse
  task automatic compare_all(input result_t exp[$], input vid_t id);
    if (got_q.size() != exp.size()) begin
      err_cnt++;
      $display("ERR %0t: %0d words, expected %0d", $time, got_q.size(), exp.size());
    end
    foreach (exp[i]) begin
      check_result(got_q[i], exp[i], i);
    end
    if (done_q.size() != 1) begin
      err_cnt++;
      $display("ERR %0t: %0d done pulses, expected 1", $time, done_q.size());
    end else begin
      check_done(done_q[0], id);
    end
  endtask

  task automatic run_insn(input insn_t insn, input opnd_beat_t beats[$], input result_t exp[$]);
    got_q.delete();
    done_q.delete();
    send_insn(insn);
    foreach (beats[i]) begin
      send_beat(beats[i]);
    end
    wait_results(exp.size());
    compare_all(exp, insn.id);
  endtask

  // Merge words expected for a random operand stream
  task automatic build_merge(input int vl, input logic vm, input vaddr_t vd, input vid_t id,
                             output opnd_beat_t beats[$], output result_t exp[$]);
    opnd_beat_t bt;
    result_t    r;
    int         nb;
    nb = (vl + 63) / 64;
    for (int w = 0; w < nb; w++) begin
      bt = random_beat();
      beats.push_back(bt);
      r.wdata = blend(bt.a, bt, (vl - 64 * w > 64) ? 64 : vl - 64 * w, vm);
      r.addr  = vd + vaddr_t'(w);
      r.id    = id;
      r.last  = (w == nb - 1);
      exp.push_back(r);
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    opnd_beat_t beats[$];
    opnd_beat_t none[$];
    result_t    exp[$];
    int         first;
    first = err_cnt;
    check_flag("insn_ready_o", insn_ready_o, 1'b1);
    check_flag("res_valid_o", res_valid_o, 1'b0);
    check_flag("done_o", done_o, 1'b0);
    check_flag("opnd_credit_o", opnd_credit_o, 1'b0);
    build_merge(64 * `MASKU_OPND_DEPTH, 1'b1, 8'h08, 3'd7, beats, exp);
    // Buffer takes the initial credits with no instruction to drain it
    foreach (beats[i]) begin
      send_beat(beats[i]);
    end
    repeat (5) begin
      next_cycle();
    end
    if (opnd_credits != 0 || credit_pulses != 0) begin
      err_cnt++;
      $display("ERR %0t: credits %0d pulses %0d before any pop", $time, opnd_credits,
               credit_pulses);
    end
    run_insn(make_insn(OP_MLOGIC, EW8, 1'b1, 64 * `MASKU_OPND_DEPTH, 8'h08, 3'd7), none, exp);
    if (credit_pulses != `MASKU_OPND_DEPTH) begin
      err_cnt++;
      $display("ERR %0t: %0d credit pulses after drain", $time, credit_pulses);
    end
    report_test("reset and initial credits", first);
  endtask

  task automatic test_merge(input string name, input int vl, input logic vm, input vaddr_t vd,
                            input vid_t id);
    opnd_beat_t beats[$];
    result_t    exp[$];
    int         first;
    first = err_cnt;
    build_merge(vl, vm, vd, id, beats, exp);
    run_insn(make_insn(OP_MLOGIC, EW8, vm, vl, vd, id), beats, exp);
    report_test(name, first);
  endtask

  task automatic test_pack(input string name, input sew_e sew, input int vl, input logic vm,
                           input vaddr_t vd, input vid_t id);
    opnd_beat_t beats[$];
    result_t    exp[$];
    opnd_beat_t cb;
    result_t    r;
    word_t      acc;
    int         epb, ew, nb, nw, cnt, g, first;
    first = err_cnt;
    // Elements per beat and element width in bits
    epb = 8 >> int'(sew);
    ew  = 8 << int'(sew);
    nb  = (vl + epb - 1) / epb;
    nw  = (vl + 63) / 64;
    for (int i = 0; i < nb; i++) begin
      beats.push_back(random_beat());
    end
    for (int w = 0; w < nw; w++) begin
      cnt = (vl - 64 * w > 64) ? 64 : vl - 64 * w;
      acc = '0;
      for (int e = 0; e < cnt; e++) begin
        g      = 64 * w + e;
        acc[e] = beats[g / epb].a[(g % epb) * ew];
      end
      // Tail and mask come from the beat that closes the word
      cb      = beats[(64 * w + cnt - 1) / epb];
      r.wdata = blend(acc, cb, cnt, vm);
      r.addr  = vd + vaddr_t'(w);
      r.id    = id;
      r.last  = (w == nw - 1);
      exp.push_back(r);
    end
    run_insn(make_insn(OP_MCMP, sew, vm, vl, vd, id), beats, exp);
    report_test(name, first);
  endtask

  task automatic test_backpressure();
    opnd_beat_t beats[$];
    result_t    exp[$];
    int         first;
    first = err_cnt;
    build_merge(6 * 64, 1'b0, 8'hA0, 3'd6, beats, exp);
    got_q.delete();
    done_q.delete();
    hold_credits = 1'b1;
    send_insn(make_insn(OP_MLOGIC, EW8, 1'b0, 6 * 64, 8'hA0, 3'd6));
    for (int i = 0; i < 4; i++) begin
      send_beat(beats[i]);
    end
    // Observation window with the sink silent
    repeat (20) begin
      next_cycle();
      check_flag("insn_ready_o under stall", insn_ready_o, 1'b0);
    end
    if (got_q.size() != `MASKU_RES_CREDITS) begin
      err_cnt++;
      $display("ERR %0t: %0d words sent while credits were held", $time, got_q.size());
    end
    hold_credits = 1'b0;
    for (int i = 4; i < 6; i++) begin
      send_beat(beats[i]);
    end
    wait_results(exp.size());
    compare_all(exp, 3'd6);
    report_test("back-pressure", first);
  endtask

  initial begin
    void'($urandom(6));
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    insn_i           = '0;
    insn_valid_i     = 1'b0;
    opnd_i           = '0;
    opnd_valid_i     = 1'b0;
    res_credit_i     = 1'b0;
    opnd_credits     = `MASKU_OPND_DEPTH;
    credit_pulses    = 0;
    owed_credits     = 0;
    sink_outstanding = 0;
    hold_credits     = 1'b0;
    err_cnt          = 0;
    test_cnt         = 0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_merge("merge unmasked vl=150", 150, 1'b1, 8'h20, 3'd1);
    test_merge("merge masked vl=200", 200, 1'b0, 8'h40, 3'd2);
    test_pack("pack EW8 masked", EW8, 100, 1'b0, 8'h60, 3'd3);
    test_pack("pack EW16 masked", EW16, 100, 1'b0, 8'h70, 3'd4);
    test_pack("pack EW64 unmasked", EW64, 100, 1'b1, 8'h80, 3'd5);
    test_backpressure();
    $display("tests %0d errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+design
+incdir+test
design/masku_cfg_pkg.sv
design/masku_insn_pkg.sv
design/masku_fifo.sv
design/masku_decode.sv
design/masku_execute.sv
design/masku_result.sv
design/masku_top.sv
test/tb_masku.sv

// ==== Bender.yml ====
package:
  name: masku

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/masku_cfg_pkg.sv
      - design/masku_insn_pkg.sv
      - design/masku_fifo.sv
      - design/masku_decode.sv
      - design/masku_execute.sv
      - design/masku_result.sv
      - design/masku_top.sv
  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/tb_masku.sv
